/* all.f */
+incdir+design
design/mera_pkg.sv
design/puks.sv
design/mem_map.sv
design/mem_store.sv
design/mera_bus_top.sv
testbench/tb_mera_bus.sv

/* run.sh */
#!/usr/bin/env bash
# build the memory-side testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mera_bus -f all.f -o tb_mera_bus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_mera_bus > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	echo "RESULT: PASS"
	exit 0
else
	echo "RESULT: FAIL"
	exit 1
fi

/* testbench/tb_mera_bus.sv */
// testbench for the MERA-400 memory side
//   clock, reset and bus master tasks
//   reference model of map, memory, supply state and clear pulses
//   concurrent assertions on ok, dt_out, pon, pout and clo
//   watchdog

`timescale 1ns/10ps

`include "mera_cfg.svh"

module tb_mera_bus;

	import mera_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int N_TESTS = 6;
	localparam int WATCHDOG_CYCLES = N_TESTS * 200 + 400;
	// master gives up after this many cycles without ok
	localparam int OK_WAIT = 10;

	logic clk = 1'b0;
	logic rst;
	logic off;
	logic dcl;
	logic dmcl;
	logic w;
	logic r;
	logic s;
	nb_t nb;
	word_t ad;
	word_t dt_in;
	word_t dt_out;
	logic ok;
	logic pon;
	logic pout;
	logic clo;

	// reference model, key is block * 16 + page
	int map_model [int];
	word_t mem_model [int];
	logic [31:0] rng;
	logic exp_hit;
	logic exp_rd;
	word_t exp_data;
	int strobe_age;
	int off_low;
	int clo_left;
	logic strobe;
	logic clr_request;
	logic ok_exp;
	logic pon_exp;
	logic clo_exp;
	word_t dt_exp;
	word_t d0;
	word_t d1;
	offset_t off_a;
	offset_t off_c;

	mera_bus_top i_dut (
		.clk(clk),
		.rst(rst),
		.off(off),
		.dcl(dcl),
		.dmcl(dmcl),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt_in(dt_in),
		.dt_out(dt_out),
		.ok(ok),
		.pon(pon),
		.pout(pout),
		.clo(clo)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// expected bus answer and supply state
	// ------------------------------------------------------------------------

	assign strobe = w | r | s;
	// ok two cycles into a mapped request, one cycle past the strobe
	assign ok_exp = exp_hit && (strobe_age >= 2);
	assign dt_exp = (ok_exp && exp_rd) ? exp_data : '0;
	assign pon_exp = (off_low >= `PON_DLY_TICKS);
	assign clo_exp = (clo_left > 0);
	// last cycle of the power-on delay, or a clear with the supply up
	assign clr_request = (!off && off_low == `PON_DLY_TICKS - 1) || (pon_exp && (dcl || dmcl));

	always @(posedge clk) begin
		if (rst || !strobe) begin
			strobe_age <= 0;
		end else if (strobe_age < 3) begin
			strobe_age <= strobe_age + 1;
		end
		if (rst || off) begin
			off_low <= 0;
			clo_left <= 0;
		end else begin
			if (off_low < `PON_DLY_TICKS) begin
				off_low <= off_low + 1;
			end
			if (clr_request) begin
				clo_left <= `CLR_TICKS;
			end else if (clo_left > 0) begin
				clo_left <= clo_left - 1;
			end
		end
	end

	a_ok: assert property (@(posedge clk) disable iff (rst) ok == ok_exp)
		else show_mismatch("ok", {15'd0, $sampled(ok)}, {15'd0, $sampled(ok_exp)});
	a_dt_out: assert property (@(posedge clk) disable iff (rst) dt_out == dt_exp)
		else show_mismatch("dt_out", $sampled(dt_out), $sampled(dt_exp));
	a_pon: assert property (@(posedge clk) disable iff (rst) pon == pon_exp)
		else show_mismatch("pon", {15'd0, $sampled(pon)}, {15'd0, $sampled(pon_exp)});
	a_pout: assert property (@(posedge clk) disable iff (rst) pout == !pon_exp)
		else show_mismatch("pout", {15'd0, $sampled(pout)}, {15'd0, !$sampled(pon_exp)});
	a_clo: assert property (@(posedge clk) disable iff (rst) clo == clo_exp)
		else show_mismatch("clo", {15'd0, $sampled(clo)}, {15'd0, $sampled(clo_exp)});

	// ------------------------------------------------------------------------
	// failure handling and helpers
	// ------------------------------------------------------------------------

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic show_mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic report_problem(input string what);
		$display("%0t: %s", $time, what);
		stop_run();
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_word(output word_t d);
		rng = xorshift(rng);
		d = rng[15:0];
	endtask

	function automatic int map_key(input nb_t blk, input word_t addr);
		return int'(blk) * 16 + int'(addr[0:3]);
	endfunction

	// physical word address from the model map
	function automatic int phys_addr(input int frame, input word_t addr);
		return frame * `MEM_PAGE_WORDS + int'(addr[4:15]);
	endfunction

	// ------------------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------------------

	// strobe up, wait for ok or give up, strobe down
	task automatic drive_request(input logic wr, input logic rd, input logic sp, input nb_t blk,
		input word_t addr, input word_t data, input logic hit, input word_t rd_exp,
		output logic answered);
		int n;
		@(negedge clk);
		// expectations change only once the previous answer is gone
		exp_hit = hit;
		exp_rd = rd;
		exp_data = rd_exp;
		nb = blk;
		ad = addr;
		dt_in = data;
		w = wr;
		r = rd;
		s = sp;
		answered = 1'b0;
		n = 0;
		while (!answered && n < OK_WAIT) begin
			@(negedge clk);
			answered = ok;
			n++;
		end
		w = 1'b0;
		r = 1'b0;
		s = 1'b0;
	endtask

	task automatic bus_write(input nb_t blk, input word_t addr, input word_t data);
		logic hit;
		logic answered;
		hit = map_model.exists(map_key(blk, addr));
		drive_request(1'b1, 1'b0, 1'b0, blk, addr, data, hit, '0, answered);
		if (hit) begin
			if (!answered) begin
				report_problem("write to a mapped page got no ok");
			end
			mem_model[phys_addr(map_model[map_key(blk, addr)], addr)] = data;
		end
	endtask

	task automatic bus_read(input nb_t blk, input word_t addr);
		logic hit;
		logic answered;
		int pa;
		word_t rd_exp;
		hit = map_model.exists(map_key(blk, addr));
		rd_exp = '0;
		if (hit) begin
			pa = phys_addr(map_model[map_key(blk, addr)], addr);
			if (mem_model.exists(pa)) begin
				rd_exp = mem_model[pa];
			end
		end
		drive_request(1'b0, 1'b1, 1'b0, blk, addr, '0, hit, rd_exp, answered);
		if (hit && !answered) begin
			report_problem("read from a mapped page got no ok");
		end
	endtask

	task automatic bus_config(input nb_t blk, input page_t pg, input logic valid, input frame_t fr);
		logic answered;
		word_t addr;
		addr = {pg, 12'h000};
		drive_request(1'b1, 1'b0, 1'b1, blk, addr, {valid, 13'd0, fr}, 1'b1, '0,
			answered);
		if (!answered) begin
			report_problem("configure cycle got no ok");
		end
		if (valid) begin
			map_model[map_key(blk, addr)] = int'(fr);
		end else begin
			map_model.delete(map_key(blk, addr));
		end
	endtask

	// ------------------------------------------------------------------------
	// power and clears
	// ------------------------------------------------------------------------

	task automatic load_default_map();
		map_model.delete();
		map_model[0] = 0;
		map_model[1] = 1;
	endtask

	task automatic wait_clear_done();
		int n;
		n = 0;
		while (clo !== 1'b0 && n < 4 * `CLR_TICKS) begin
			@(negedge clk);
			n++;
		end
		if (clo !== 1'b0) begin
			report_problem("clo stayed high after a clear pulse");
		end
	endtask

	task automatic power_on();
		int n;
		@(negedge clk);
		off = 1'b0;
		n = 0;
		while (pon !== 1'b1 && n < `PON_DLY_TICKS + 5) begin
			@(negedge clk);
			n++;
		end
		if (pon !== 1'b1) begin
			report_problem("pon never came up after off fell");
		end
		wait_clear_done();
	endtask

	task automatic pulse_clear(input logic panel);
		@(negedge clk);
		dcl = panel;
		dmcl = !panel;
		@(negedge clk);
		dcl = 1'b0;
		dmcl = 1'b0;
		// only the panel clear brings back the default map
		if (panel) begin
			load_default_map();
		end
		wait_clear_done();
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		rng = 32'h5e42202f;
		rst = 1'b1;
		off = 1'b1;
		dcl = 1'b0;
		dmcl = 1'b0;
		w = 1'b0;
		r = 1'b0;
		s = 1'b0;
		nb = '0;
		ad = '0;
		dt_in = '0;
		exp_hit = 1'b0;
		exp_rd = 1'b0;
		exp_data = '0;
		off_a = 12'h123;
		off_c = 12'hffe;
		load_default_map();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// power-on delay and first clear
		power_on();

		// default map, block 0 pages 0 and 1
		next_word(d0);
		next_word(d1);
		bus_write(4'd0, {4'd0, off_a}, d0);
		bus_write(4'd0, {4'd1, off_a}, d1);
		bus_read(4'd0, {4'd0, off_a});
		bus_read(4'd0, {4'd1, off_a});

		// unmapped blocks and pages stay silent
		next_word(d0);
		bus_read(4'd2, {4'd0, off_a});
		bus_write(4'd2, {4'd0, off_a}, d0);
		bus_write(4'd0, {4'd5, off_a}, d0);
		bus_read(4'd0, {4'd5, off_a});
		bus_read(4'd0, {4'd0, off_a});
		bus_read(4'd0, {4'd1, off_a});

		// block 3 page 7 aliased onto frame 1
		bus_config(4'd3, 4'd7, 1'b1, 2'd1);
		next_word(d0);
		next_word(d1);
		bus_write(4'd3, {4'd7, off_c}, d0);
		bus_read(4'd0, {4'd1, off_c});
		bus_write(4'd0, {4'd1, off_a}, d1);
		bus_read(4'd3, {4'd7, off_a});

		// panel clear drops the alias, data stays
		pulse_clear(1'b1);
		bus_read(4'd3, {4'd7, off_c});
		bus_read(4'd0, {4'd1, off_c});

		// cpu master clear keeps the map
		bus_config(4'd3, 4'd7, 1'b1, 2'd1);
		pulse_clear(1'b0);
		bus_read(4'd3, {4'd7, off_c});
		bus_read(4'd3, {4'd7, off_a});

		repeat (2) @(negedge clk);
		$display("All tests passed!");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_problem("watchdog expired before the test sequence finished");
	end

endmodule

/* design/mera_bus_top.sv */
// MERA-400 memory side top level
//   power supply and clear sequencer
//   memory configuration map
//   memory bus slave with word array

`timescale 1ns/10ps

module mera_bus_top (
	input logic clk,
	input logic rst,
	// power switch and clears
	input logic off,
	input logic dcl,
	input logic dmcl,
	// system bus
	input logic w,
	input logic r,
	input logic s,
	input mera_pkg::nb_t nb,
	input mera_pkg::word_t ad,
	input mera_pkg::word_t dt_in,
	output mera_pkg::word_t dt_out,
	output logic ok,
	// supply state
	output logic pon,
	output logic pout,
	output logic clo
);

	import mera_pkg::*;

	// ------------------------------------------------------------------------
	// power supply
	// ------------------------------------------------------------------------

	// memory clear, only the map sees it
	logic clm;

	puks i_puks (
		.clk(clk),
		.rst(rst),
		.off(off),
		.dcl(dcl),
		.dmcl(dmcl),
		.pon(pon),
		.pout(pout),
		.clo(clo),
		.clm(clm)
	);

	// ------------------------------------------------------------------------
	// memory
	// ------------------------------------------------------------------------

	logic cfg_we;
	logic cfg_valid;
	frame_t cfg_frame;
	nb_t lookup_nb;
	page_t lookup_page;
	logic lookup_valid;
	frame_t lookup_frame;

	// configure entry shares the lookup address
	mem_map i_mem_map (
		.clk(clk),
		.rst(rst),
		.clm(clm),
		.cfg_we(cfg_we),
		.cfg_nb(lookup_nb),
		.cfg_page(lookup_page),
		.cfg_valid(cfg_valid),
		.cfg_frame(cfg_frame),
		.lookup_nb(lookup_nb),
		.lookup_page(lookup_page),
		.lookup_valid(lookup_valid),
		.lookup_frame(lookup_frame)
	);

	mem_store i_mem_store (
		.clk(clk),
		.rst(rst),
		.w(w),
		.r(r),
		.s(s),
		.nb(nb),
		.ad(ad),
		.dt_in(dt_in),
		.dt_out(dt_out),
		.ok(ok),
		.cfg_we(cfg_we),
		.cfg_valid(cfg_valid),
		.cfg_frame(cfg_frame),
		.lookup_nb(lookup_nb),
		.lookup_page(lookup_page),
		.lookup_valid(lookup_valid),
		.lookup_frame(lookup_frame)
	);

endmodule

/* design/mem_store.sv */
// memory bus slave
//   strobe edge detection and request decode
//   map lookup, registered one cycle after the strobe
//   configure pulses towards the map
//   word array of MEM_FRAMES frames
//   ok and read data by the bus timing

`timescale 1ns/10ps

`include "mera_cfg.svh"

module mem_store (
	input logic clk,
	input logic rst,
	// system bus
	input logic w,
	input logic r,
	input logic s,
	input mera_pkg::nb_t nb,
	input mera_pkg::word_t ad,
	input mera_pkg::word_t dt_in,
	output mera_pkg::word_t dt_out,
	output logic ok,
	// map update
	output logic cfg_we,
	output logic cfg_valid,
	output mera_pkg::frame_t cfg_frame,
	// map lookup
	output mera_pkg::nb_t lookup_nb,
	output mera_pkg::page_t lookup_page,
	input logic lookup_valid,
	input mera_pkg::frame_t lookup_frame
);

	import mera_pkg::*;

	localparam int MEM_WORDS = `MEM_FRAMES * `MEM_PAGE_WORDS;
	localparam int AW = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_ANSWER,
		ST_WAIT
	} state_t;

	state_t state_q;
	logic strobe;
	logic is_cfg;
	logic is_wr;
	logic is_rd;
	logic req_cfg_q;
	logic req_wr_q;
	logic req_rd_q;
	logic hit_q;
	// request will be answered with ok
	logic grant;
	frame_t frame_q;
	offset_t off_q;
	word_t rdata_q;
	logic [AW-1:0] mem_addr;
	word_t mem [0:MEM_WORDS-1];

	// ------------------------------------------------------------------------
	// request decode
	// ------------------------------------------------------------------------

	assign strobe = w | r | s;
	// s with w is a configure cycle
	assign is_cfg = s & w & ~r;
	assign is_wr = w & ~r & ~s;
	assign is_rd = r & ~w & ~s;

	// address goes to the map as is
	assign lookup_nb = nb;
	assign lookup_page = page_of(ad);

	// configure data: bit 0 valid, bits 14..15 frame
	assign cfg_we = (state_q == ST_LOOKUP) && req_cfg_q;
	assign cfg_valid = dt_in[0];
	assign cfg_frame = dt_in[14:15];

	// unmapped or unknown requests stay silent
	assign grant = req_cfg_q || (hit_q && (req_wr_q || req_rd_q));

	// ------------------------------------------------------------------------
	// bus FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			req_cfg_q <= 1'b0;
			req_wr_q <= 1'b0;
			req_rd_q <= 1'b0;
			hit_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (strobe) begin
						state_q <= ST_LOOKUP;
						req_cfg_q <= is_cfg;
						req_wr_q <= is_wr;
						req_rd_q <= is_rd;
						hit_q <= lookup_valid;
					end
				end
				ST_LOOKUP: begin
					// master gave up early
					if (!strobe) begin
						state_q <= ST_IDLE;
					end else if (grant) begin
						state_q <= ST_ANSWER;
					end else begin
						state_q <= ST_WAIT;
					end
				end
				// ok held until the strobe falls
				ST_ANSWER, ST_WAIT: begin
					if (!strobe) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// word array
	// ------------------------------------------------------------------------

	// frame and offset captured with the strobe
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && strobe) begin
			frame_q <= lookup_frame;
			off_q <= offset_of(ad);
		end
	end

	assign mem_addr = {frame_q, off_q};

	// array touched once, in the cycle before ok
	always_ff @(posedge clk) begin
		if (state_q == ST_LOOKUP && strobe && hit_q) begin
			if (req_wr_q) begin
				mem[mem_addr] <= dt_in;
			end
			if (req_rd_q) begin
				rdata_q <= mem[mem_addr];
			end
		end
	end

	assign ok = (state_q == ST_ANSWER);
	// data bus idles at zero
	assign dt_out = (ok && req_rd_q) ? rdata_q : '0;

endmodule

/* design/mem_map.sv */
// memory configuration block
//   page-to-frame map, one entry per block and logical page
//   written by configure cycles from the bus slave
//   default map restored on reset and on clm
//   combinational lookup for the bus slave

`timescale 1ns/10ps

`include "mera_cfg.svh"

module mem_map (
	input logic clk,
	input logic rst,
	// memory clear from the power sequencer
	input logic clm,
	// configure port
	input logic cfg_we,
	input mera_pkg::nb_t cfg_nb,
	input mera_pkg::page_t cfg_page,
	input logic cfg_valid,
	input mera_pkg::frame_t cfg_frame,
	// lookup port
	input mera_pkg::nb_t lookup_nb,
	input mera_pkg::page_t lookup_page,
	output logic lookup_valid,
	output mera_pkg::frame_t lookup_frame
);

	import mera_pkg::*;

	localparam int MAP_ENTRIES = 2 ** ($bits(nb_t) + $bits(page_t));

	// default map entries, block 0 pages 0 and 1
	localparam map_idx_t DEF_IDX0 = 8'd0;
	localparam map_idx_t DEF_IDX1 = 8'd1;
	localparam frame_t DEF_FRAME0 = 2'd0;
	localparam frame_t DEF_FRAME1 = 2'd1;

	logic valid_q [0:MAP_ENTRIES-1];
	frame_t frame_q [0:MAP_ENTRIES-1];
	map_idx_t wr_idx;
	map_idx_t rd_idx;
	logic clear;

	assign clear = rst || clm;
	assign wr_idx = map_idx(cfg_nb, cfg_page);
	assign rd_idx = map_idx(lookup_nb, lookup_page);

	// ------------------------------------------------------------------------
	// valid flags
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (clear) begin
			// held in the default state while clm is up
			for (int i = 0; i < MAP_ENTRIES; i++) begin
				valid_q[i] <= 1'b0;
			end
			valid_q[DEF_IDX0] <= 1'b1;
			valid_q[DEF_IDX1] <= 1'b1;
		end else if (cfg_we) begin
			valid_q[wr_idx] <= cfg_valid;
		end
	end

	// ------------------------------------------------------------------------
	// frame numbers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (clear) begin
			// only the default entries need a frame
			frame_q[DEF_IDX0] <= DEF_FRAME0;
			frame_q[DEF_IDX1] <= DEF_FRAME1;
		end else if (cfg_we) begin
			frame_q[wr_idx] <= cfg_frame;
		end
	end

	// lookup straight from the table
	assign lookup_valid = valid_q[rd_idx];
	assign lookup_frame = frame_q[rd_idx];

endmodule

/* design/puks.sv */
// power supply and clear sequencer
//   power-on delay after the switch is turned on
//   pon / pout supply state
//   clm + clo pulse on power-on and panel clear
//   clo pulse alone on cpu master clear (isk merging)

`timescale 1ns/10ps

`include "mera_cfg.svh"

module puks (
	input logic clk,
	input logic rst,
	// power switch, high means switched off
	input logic off,
	// panel clear
	input logic dcl,
	// cpu master clear
	input logic dmcl,
	output logic pon,
	output logic pout,
	output logic clo,
	output logic clm
);

	localparam int DLY_W = $clog2(`PON_DLY_TICKS + 1);
	localparam int CLR_W = $clog2(`CLR_TICKS + 1);

	logic [DLY_W-1:0] dly_cnt;
	logic [CLR_W-1:0] clr_cnt;
	logic pon_q;
	logic clo_q;
	logic clm_q;
	// last cycle of the power-on delay
	logic pon_rise;
	logic clm_req;
	logic clo_req;

	// ------------------------------------------------------------------------
	// supply state
	// ------------------------------------------------------------------------

	assign pon_rise = !off && !pon_q && (dly_cnt == DLY_W'(`PON_DLY_TICKS - 1));

	always_ff @(posedge clk) begin
		if (rst || off) begin
			// switch off kills the supply at once
			dly_cnt <= '0;
			pon_q <= 1'b0;
		end else if (!pon_q) begin
			if (pon_rise) begin
				pon_q <= 1'b1;
			end else begin
				dly_cnt <= dly_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// clear pulses
	// ------------------------------------------------------------------------

	// isk: both clears only with the supply up
	// power-on counts as a full clear
	assign clm_req = pon_rise || (pon_q && dcl);
	// master clear from the cpu resets the interfaces only
	assign clo_req = clm_req || (pon_q && dmcl);

	always_ff @(posedge clk) begin
		if (rst || off) begin
			clo_q <= 1'b0;
			clm_q <= 1'b0;
			clr_cnt <= '0;
		end else if (clo_req) begin
			// new request restarts the count
			clo_q <= 1'b1;
			// a running clm stays up through a restart
			clm_q <= clm_q | clm_req;
			clr_cnt <= CLR_W'(`CLR_TICKS - 1);
		end else if (clo_q) begin
			if (clr_cnt == '0) begin
				clo_q <= 1'b0;
				clm_q <= 1'b0;
			end else begin
				clr_cnt <= clr_cnt - 1'b1;
			end
		end
	end

	assign pon = pon_q;
	// pout is the inverse supply flag
	assign pout = !pon_q;
	assign clo = clo_q;
	assign clm = clm_q;

endmodule

/* design/mera_pkg.sv */
// MERA-400 memory side, shared bus types
//   word_t   - 16-bit bus word, bit 0 is the msb
//   nb_t     - memory block number (dnb)
//   page_t   - logical page from address bits 0..3
//   frame_t  - physical frame number
//   offset_t - word offset inside a page, address bits 4..15
//   map index helpers used by the map and the store

package mera_pkg;

	// bus word, numbered as on the real backplane
	typedef logic [0:15] word_t;

	// block number travels beside the address
	typedef logic [0:3] nb_t;

	// top nibble of the address picks the logical page
	typedef logic [0:3] page_t;

	// two bits for four frames of 4k words
	typedef logic [0:1] frame_t;

	// rest of the address, word inside the page
	typedef logic [0:11] offset_t;

	// one map entry per block and page
	typedef logic [7:0] map_idx_t;

	function automatic page_t page_of(input word_t ad);
		return ad[0:3];
	endfunction

	function automatic offset_t offset_of(input word_t ad);
		return ad[4:15];
	endfunction

	function automatic map_idx_t map_idx(input nb_t nb, input page_t page);
		return {nb, page};
	endfunction

endpackage

/* design/mera_cfg.svh */
// MERA-400 memory side, build constants
//   physical memory size
//   power-on delay and clear pulse length, in clock cycles

`ifndef MERA_CFG_SVH
`define MERA_CFG_SVH

// ------------------------------------------------------------------------
// memory
// ------------------------------------------------------------------------

// physical frames behind the map, matches the width of frame_t
`define MEM_FRAMES 4

// words in one frame, same as words in one logical page
`define MEM_PAGE_WORDS 4096

// ------------------------------------------------------------------------
// power supply
// ------------------------------------------------------------------------

// off low this long before pon comes up
`define PON_DLY_TICKS 20

// each clo / clm pulse lasts this many cycles
`define CLR_TICKS 4

`endif
